// ==== Makefile ====
# Verilator build for the APB3 fabric

TOP := apbFabricTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+verification
source/apbFabricPkg.sv
source/slotDecoder.sv
source/responseMux.sv
source/indirectAddrReg.sv
source/addrInfill.sv
source/apbFabric.sv
verification/apbFabricTb.sv

// ==== source/addrInfill.sv ====
//##############################
// Slave address widening
//##############################

`timescale 1ns/100ps
`default_nettype none

module addrInfill #(
    parameter int unsigned MasterAddrBits = 16,
    parameter int unsigned UpperNibblePos = 7
) (
    input  wire [MasterAddrBits-1:0]  paddr,
    input  wire apbFabricPkg::data_t  indirectAddr,
    output apbFabricPkg::addr_t       paddrS
);

    import apbFabricPkg::*;

    // Master bits below the slot nibble
    localparam int unsigned LowBits   = MasterAddrBits - SlotIdxBits;
    localparam int unsigned NibbleLsb = SlotIdxBits * UpperNibblePos;

    localparam addr_t LowMask    = (addr_t'(1) << LowBits) - addr_t'(1);
    localparam addr_t NibbleMask = addr_t'({SlotIdxBits{1'b1}}) << NibbleLsb;
    // Everything else is taken from the register
    localparam addr_t FillMask   = ~(LowMask | NibbleMask);

    if ((UpperNibblePos > 7) || (NibbleLsb < LowBits) || (MasterAddrBits <= SlotIdxBits))
    begin : g_badParams
        $error("addrInfill: slot nibble %0d overlaps %0d master bits",
               UpperNibblePos, MasterAddrBits);
    end

    addr_t lowPart;
    addr_t nibblePart;
    addr_t fillPart;

    assign lowPart    = addr_t'(paddr) & LowMask;
    assign nibblePart = addr_t'(paddr[MasterAddrBits-1 -: SlotIdxBits]) << NibbleLsb;
    assign fillPart   = addr_t'(indirectAddr) & FillMask;

    // Nibble at the top gives plain zero-extension plus register bits
    assign paddrS = lowPart | nibblePart | fillPart;

endmodule

`default_nettype wire

// ==== source/apbFabric.sv ====
//##############################
// APB3 fabric top level
//##############################

`timescale 1ns/100ps
`default_nettype none

module apbFabric #(
    parameter int unsigned             MasterAddrBits = 16,
    parameter int unsigned             UpperNibblePos = 7,
    parameter apbFabricPkg::slotMask_t SlotEnable     = '1,
    parameter apbFabricPkg::slotIdx_t  IndirectSlot   = 4'd15
) (
    input  wire                           pclk,
    input  wire                           arstN,
    // Master side
    input  wire [MasterAddrBits-1:0]      paddr,
    input  wire                           psel,
    input  wire                           penable,
    input  wire                           pwrite,
    input  wire apbFabricPkg::data_t      pwdata,
    output apbFabricPkg::data_t           prdata,
    output logic                          pready,
    output logic                          pslverr,
    // Slave side
    output apbFabricPkg::addr_t           paddrS,
    output apbFabricPkg::slotMask_t       pselS,
    output logic                          penableS,
    output logic                          pwriteS,
    output apbFabricPkg::data_t           pwdataS,
    input  wire apbFabricPkg::slotData_t  prdataS,
    input  wire apbFabricPkg::slotMask_t  preadyS,
    input  wire apbFabricPkg::slotMask_t  pslverrS
);

    import apbFabricPkg::*;

    slotIdx_t  slotIdx;
    slotMask_t slotSel;
    logic      indirectSel;
    data_t     indirectAddr;

    // Slot comes from the top nibble of the master address
    assign slotIdx = paddr[MasterAddrBits-1 -: SlotIdxBits];

    slotDecoder #(
        .SlotEnable   (SlotEnable),
        .IndirectSlot (IndirectSlot)
    ) slotDecoder_i (
        .psel        (psel),
        .slotIdx     (slotIdx),
        .slotSel     (slotSel),
        .indirectSel (indirectSel)
    );

    responseMux responseMux_i (
        .slotSel      (slotSel),
        .indirectSel  (indirectSel),
        .indirectAddr (indirectAddr),
        .prdataS      (prdataS),
        .preadyS      (preadyS),
        .pslverrS     (pslverrS),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr)
    );

    indirectAddrReg indirectAddrReg_i (
        .pclk         (pclk),
        .arstN        (arstN),
        .indirectSel  (indirectSel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .indirectAddr (indirectAddr)
    );

    addrInfill #(
        .MasterAddrBits (MasterAddrBits),
        .UpperNibblePos (UpperNibblePos)
    ) addrInfill_i (
        .paddr        (paddr),
        .indirectAddr (indirectAddr),
        .paddrS       (paddrS)
    );

    // Request broadcast to every slot
    assign pselS    = slotSel;
    assign penableS = penable;
    assign pwriteS  = pwrite;
    assign pwdataS  = pwdata;

endmodule

`default_nettype wire

// ==== source/apbFabricPkg.sv ====
//##############################
// APB3 fabric shared types
//##############################

`default_nettype none

package apbFabricPkg;

    // Slot space is the top address nibble
    localparam int unsigned SlotCount   = 16;
    localparam int unsigned SlotIdxBits = 4;

    localparam int unsigned DataWidth = 32;
    localparam int unsigned AddrWidth = 32;

    typedef logic [SlotIdxBits-1:0] slotIdx_t;

    // One bit per slot for selects, readies, errors and enables
    typedef logic [SlotCount-1:0] slotMask_t;

    typedef logic [DataWidth-1:0] data_t;

    typedef logic [AddrWidth-1:0] addr_t;

    // Read data of every slot with slot 0 in the low word
    typedef logic [SlotCount-1:0][DataWidth-1:0] slotData_t;

endpackage

`default_nettype wire

// ==== source/indirectAddrReg.sv ====
//##############################
// Indirect address register
//##############################

`timescale 1ns/100ps
`default_nettype none

module indirectAddrReg (
    input  wire                       pclk,
    input  wire                       arstN,
    input  wire                       indirectSel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire apbFabricPkg::data_t  pwdata,
    output apbFabricPkg::data_t       indirectAddr
);

    import apbFabricPkg::*;

    logic wrEn;

    // Slot is always ready, so the first access cycle completes the write
    assign wrEn = indirectSel & penable & pwrite;

    always_ff @(posedge pclk or negedge arstN)
    begin
        if (!arstN)
        begin
            indirectAddr <= '0;
        end
        else if (wrEn)
        begin
            indirectAddr <= pwdata;
        end
    end

    // Value moves only in the cycle after a register write
    wrOnlyChange: assert property (
        @(posedge pclk) disable iff (!arstN)
        (indirectAddr != $past(indirectAddr)) |-> $past(wrEn)
    )
    else $error("indirectAddrReg: unexpected value 0x%h", indirectAddr);

endmodule

`default_nettype wire

// ==== source/responseMux.sv ====
//##############################
// APB response multiplexer
//##############################

`timescale 1ns/100ps
`default_nettype none

module responseMux (
    input  wire apbFabricPkg::slotMask_t  slotSel,
    input  wire                           indirectSel,
    input  wire apbFabricPkg::data_t      indirectAddr,
    input  wire apbFabricPkg::slotData_t  prdataS,
    input  wire apbFabricPkg::slotMask_t  preadyS,
    input  wire apbFabricPkg::slotMask_t  pslverrS,
    output apbFabricPkg::data_t           prdata,
    output logic                          pready,
    output logic                          pslverr
);

    import apbFabricPkg::*;

    // Select is one-hot or zero, so at most one slot wins the loop
    always_comb
    begin
        prdata  = '0;
        pready  = 1'b1;
        pslverr = 1'b0;
        if (indirectSel)
        begin
            // Register slot is always ready and never errors
            prdata = indirectAddr;
        end
        else
        begin
            for (int i = 0; i < SlotCount; i++)
            begin
                if (slotSel[i])
                begin
                    prdata  = prdataS[i];
                    pready  = preadyS[i];
                    pslverr = pslverrS[i];
                end
            end
        end
    end

    // Error is only meaningful on the completing cycle
    always_comb
    begin
        assert final (!(pslverr && !pready))
        else $error("responseMux: pslverr raised while pready low, select 0x%h", slotSel);
    end

endmodule

`default_nettype wire

// ==== source/slotDecoder.sv ====
//##############################
// APB slot select decoder
//##############################

`timescale 1ns/100ps
`default_nettype none

module slotDecoder #(
    parameter apbFabricPkg::slotMask_t SlotEnable   = '1,
    parameter apbFabricPkg::slotIdx_t  IndirectSlot = 4'd15
) (
    input  wire                          psel,
    input  wire apbFabricPkg::slotIdx_t  slotIdx,
    output apbFabricPkg::slotMask_t      slotSel,
    output logic                         indirectSel
);

    import apbFabricPkg::*;

    // Slots that may see a select on the slave side
    localparam slotMask_t Routable = SlotEnable & ~(slotMask_t'(1) << IndirectSlot);

    slotMask_t slotOneHot;

    assign slotOneHot = slotMask_t'(1) << slotIdx;

    always_comb
    begin
        slotSel     = '0;
        indirectSel = 1'b0;
        if (psel)
        begin
            slotSel     = slotOneHot & Routable;
            indirectSel = (slotIdx == IndirectSlot);
        end
    end

    // Indirect slot never shares a cycle with a slave select
    always_comb
    begin
        assert final ($onehot0(slotSel) && !(indirectSel && (|slotSel)))
        else $error("slotDecoder: bad select 0x%h indirect %b", slotSel, indirectSel);
    end

endmodule

`default_nettype wire

// ==== verification/apbFabricTasks.svh ====
//##############################
// Fabric testbench tasks
//##############################

`ifndef APB_FABRIC_TASKS_SVH
`define APB_FABRIC_TASKS_SVH

task automatic stopOnError(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
endtask

task automatic compareData(input string name, input data_t actual, input data_t expected);
    if (actual !== expected)
    begin
        stopOnError($sformatf("MISMATCH at %0d ns: %s is 0x%h, expected 0x%h",
                              $time, name, actual, expected));
    end
endtask

task automatic compareAddr(input string name, input addr_t actual, input addr_t expected);
    if (actual !== expected)
    begin
        stopOnError($sformatf("MISMATCH at %0d ns: %s is 0x%h, expected 0x%h",
                              $time, name, actual, expected));
    end
endtask

task automatic compareMask(input string name, input slotMask_t actual,
                           input slotMask_t expected);
    if (actual !== expected)
    begin
        stopOnError($sformatf("MISMATCH at %0d ns: %s is 0x%h, expected 0x%h",
                              $time, name, actual, expected));
    end
endtask

task automatic compareBit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
        stopOnError($sformatf("MISMATCH at %0d ns: %s is %b, expected %b",
                              $time, name, actual, expected));
    end
endtask

function automatic masterAddr_t addrForSlot(input slotIdx_t slot);
    lowAddr_t low;
    low = lowAddr_t'($urandom);
    return {slot, low};
endfunction

// Register slot and disabled slot never reach the slave side
function automatic slotMask_t expectedSel(input slotIdx_t slot);
    if ((slot == DisabledSlot) || (slot == IndirectSlot))
    begin
        return '0;
    end
    return slotMask_t'(1) << slot;
endfunction

function automatic data_t expectedData(input slotIdx_t slot);
    if (slot == DisabledSlot)
    begin
        return '0;
    end
    return slaveData[slot];
endfunction

function automatic logic expectedErr(input slotIdx_t slot);
    if ((slot == DisabledSlot) || (slot == IndirectSlot))
    begin
        return 1'b0;
    end
    return slaveErr[slot];
endfunction

// Slot nibble on top, register bits in between, master low bits kept
function automatic addr_t expectedSlaveAddr(input masterAddr_t addr, input data_t regBits);
    return {addr[15:12], regBits[27:12], addr[11:0]};
endfunction

task automatic checkRequest(input slotMask_t expSel);
    compareMask("pselS", pselS, expSel);
    compareBit("penableS", penableS, penable);
    compareBit("pwriteS", pwriteS, pwrite);
    compareData("pwdataS", pwdataS, pwdata);
endtask

task automatic checkWaits(input slotIdx_t slot, input int waitCount, input int waits);
    if (waitCount != waits)
    begin
        stopOnError($sformatf("Slot %0d completed after %0d wait cycles instead of %0d",
                              slot, waitCount, waits));
    end
endtask

// One APB3 transfer with the request checked in every phase
task automatic runTransfer(
    input  masterAddr_t addr,
    input  logic        write,
    input  data_t       wdata,
    input  int          waits,
    input  slotMask_t   expSel,
    output data_t       rdata,
    output logic        err,
    output int          waitCount
);
    int   cycles;
    logic done;
    @(posedge pclk);
    #1;
    paddr      = addr;
    pwrite     = write;
    pwdata     = wdata;
    psel       = 1'b1;
    penable    = 1'b0;
    waitCycles = waits;
    @(negedge pclk);
    checkRequest(expSel);
    @(posedge pclk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    done    = 1'b0;
    rdata   = '0;
    err     = 1'b0;
    while (!done)
    begin
        @(negedge pclk);
        checkRequest(expSel);
        if (pready)
        begin
            rdata = prdata;
            err   = pslverr;
            done  = 1'b1;
        end
        else if (cycles == TimeoutCycles)
        begin
            stopOnError($sformatf("No pready within %0d cycles for address 0x%h",
                                  TimeoutCycles, addr));
        end
        else
        begin
            cycles++;
        end
        @(posedge pclk);
    end
    #1;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    waitCount = cycles;
endtask

task automatic testResetIdle();
    data_t rdata;
    logic  err;
    int    waitCount;
    @(negedge pclk);
    compareMask("pselS", pselS, '0);
    compareBit("pready", pready, 1'b1);
    runTransfer(addrForSlot(IndirectSlot), 1'b0, '0, 0, '0, rdata, err, waitCount);
    compareData("prdata", rdata, '0);
    compareBit("pslverr", err, 1'b0);
endtask

task automatic testDecoding();
    slotIdx_t slot;
    data_t    rdata;
    logic     err;
    int       waitCount;
    for (int s = 0; s < SlotCount; s++)
    begin
        slot = slotIdx_t'(s);
        runTransfer(addrForSlot(slot), 1'b0, '0, 0, expectedSel(slot), rdata, err, waitCount);
    end
endtask

task automatic testReads();
    slotIdx_t slot;
    int       waits;
    data_t    rdata;
    logic     err;
    int       waitCount;
    for (int s = 0; s < SlotCount; s++)
    begin
        slot = slotIdx_t'(s);
        if (slot != IndirectSlot)
        begin
            waits = (slot == DisabledSlot) ? 0 : int'($urandom_range(MaxWaits, 0));
            runTransfer(addrForSlot(slot), 1'b0, '0, waits, expectedSel(slot),
                        rdata, err, waitCount);
            compareData("prdata", rdata, expectedData(slot));
            compareBit("pslverr", err, expectedErr(slot));
            checkWaits(slot, waitCount, waits);
        end
    end
endtask

task automatic testBroadcast();
    slotIdx_t slot;
    int       waits;
    data_t    rdata;
    logic     err;
    int       waitCount;
    repeat (8)
    begin
        slot  = slotIdx_t'($urandom_range(int'(IndirectSlot) - 1, 0));
        waits = (slot == DisabledSlot) ? 0 : int'($urandom_range(MaxWaits, 0));
        runTransfer(addrForSlot(slot), 1'b1, $urandom, waits, expectedSel(slot),
                    rdata, err, waitCount);
        compareBit("pslverr", err, expectedErr(slot));
        checkWaits(slot, waitCount, waits);
    end
endtask

task automatic testIndirect();
    data_t rdata;
    logic  err;
    int    waitCount;
    regValue = $urandom;
    runTransfer(addrForSlot(IndirectSlot), 1'b1, regValue, 0, '0, rdata, err, waitCount);
    compareBit("pslverr", err, 1'b0);
    runTransfer(addrForSlot(IndirectSlot), 1'b0, '0, 0, '0, rdata, err, waitCount);
    compareData("prdata", rdata, regValue);
    compareBit("pslverr", err, 1'b0);
endtask

task automatic testInfill();
    masterAddr_t addr;
    data_t       rdata;
    logic        err;
    int          waitCount;
    regValue = $urandom;
    runTransfer(addrForSlot(IndirectSlot), 1'b1, regValue, 0, '0, rdata, err, waitCount);
    repeat (20)
    begin
        addr = masterAddr_t'($urandom);
        @(posedge pclk);
        #1;
        paddr = addr;
        @(negedge pclk);
        compareAddr("paddrS", paddrS, expectedSlaveAddr(addr, regValue));
    end
endtask

`endif

// ==== verification/apbFabricTb.sv ====
//##############################
// APB3 fabric testbench
//##############################

`timescale 1ns/100ps
`default_nettype none

module apbFabricTb;

    import apbFabricPkg::*;

    localparam int unsigned MasterAddrBits = 16;
    localparam int unsigned UpperNibblePos = 7;
    localparam slotIdx_t    IndirectSlot   = 4'd15;
    localparam slotIdx_t    DisabledSlot   = 4'd13;
    localparam slotMask_t   SlotEnable     = ~(slotMask_t'(1) << DisabledSlot);
    localparam int unsigned LowBits        = MasterAddrBits - SlotIdxBits;

    localparam int unsigned ClkPeriod     = 8;
    localparam int          ResetCycles   = 16;
    localparam int          TimeoutCycles = 50;
    localparam int          MaxWaits      = 3;

    typedef logic [MasterAddrBits-1:0] masterAddr_t;
    typedef logic [LowBits-1:0]        lowAddr_t;

    logic        pclk;
    logic        arstN;
    masterAddr_t paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    data_t       pwdata;
    data_t       prdata;
    logic        pready;
    logic        pslverr;
    addr_t       paddrS;
    slotMask_t   pselS;
    logic        penableS;
    logic        pwriteS;
    data_t       pwdataS;
    slotData_t   prdataS;
    slotMask_t   preadyS;
    slotMask_t   pslverrS;

    // Slave model state
    data_t     slaveData [SlotCount];
    slotMask_t slaveErr;
    int        waitCycles;
    int        waitLeft;

    // Last value written to the indirect register
    data_t regValue;

    always
    begin
        #(ClkPeriod / 2) pclk = ~pclk;
    end

    apbFabric #(
        .MasterAddrBits (MasterAddrBits),
        .UpperNibblePos (UpperNibblePos),
        .SlotEnable     (SlotEnable),
        .IndirectSlot   (IndirectSlot)
    ) dut_i (
        .pclk     (pclk),
        .arstN    (arstN),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .paddrS   (paddrS),
        .pselS    (pselS),
        .penableS (penableS),
        .pwriteS  (pwriteS),
        .pwdataS  (pwdataS),
        .prdataS  (prdataS),
        .preadyS  (preadyS),
        .pslverrS (pslverrS)
    );

    // Wait states counted down through the access phase
    always @(posedge pclk or negedge arstN)
    begin
        if (!arstN)
        begin
            waitLeft <= 0;
        end
        else if (psel && !penable)
        begin
            waitLeft <= waitCycles;
        end
        else if (psel && penable && (waitLeft != 0))
        begin
            waitLeft <= waitLeft - 1;
        end
    end

    // Error only shows together with ready
    always_comb
    begin
        for (int i = 0; i < SlotCount; i++)
        begin
            prdataS[i]  = slaveData[i];
            preadyS[i]  = !pselS[i] || (waitLeft == 0);
            pslverrS[i] = slaveErr[i] && (!pselS[i] || (waitLeft == 0));
        end
    end

    `include "apbFabricTasks.svh"

    initial
    begin
        pclk       = 1'b0;
        arstN      = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        waitCycles = 0;
        regValue   = '0;
        void'($urandom(32'h2926_9027));
        for (int i = 0; i < SlotCount; i++)
        begin
            slaveData[i] = $urandom;
        end
        slaveErr = slotMask_t'($urandom);

        repeat (ResetCycles) @(posedge pclk);
        #1;
        arstN = 1'b1;

        testResetIdle();
        testDecoding();
        testReads();
        testBroadcast();
        testIndirect();
        testInfill();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
